/* src/riscv_isa_pkg.sv */
// ####################
// RV32IM opcode, funct3 and funct7 encodings
// instruction word union with R and I views
// ####################
`default_nettype none

package riscv_isa_pkg;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // integer ops, shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SW  = 3'b010;

    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU  = 3'b011;

    localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000; // sub, sra
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;  // shamt in [4:0] for shifts
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } inst_u;

endpackage

`default_nettype wire

/* src/ex_types_pkg.sv */
// ####################
// execute stage widths and bus types
// ####################
`default_nettype none

package ex_types_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // from decode, operands already selected
    typedef struct packed {
        logic                 valid;
        riscv_isa_pkg::inst_u inst;
        logic [XLEN-1:0]      pc;
        logic [XLEN-1:0]      op1;        // operand a, or address base
        logic [XLEN-1:0]      op2;        // operand b, or address offset
        logic [XLEN-1:0]      rs1_data;   // branch compare
        logic [XLEN-1:0]      rs2_data;
        logic [XLEN-1:0]      store_data;
    } ex_issue_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic [XLEN-1:0]       wdata;
        logic                  jump;
        logic [XLEN-1:0]       jump_addr;
    } ex_wb_t;

    typedef struct packed {
        logic            req;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } ex_mem_req_t;

    typedef enum logic [2:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_BRANCH,
        UNIT_LOAD,
        UNIT_STORE,
        UNIT_NONE
    } ex_unit_e;

endpackage

`default_nettype wire

/* src/ex_alu.sv */
// ####################
// RV32I integer ALU
// ####################
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  riscv_isa_pkg::inst_u                inst_i,
    input  logic [ex_types_pkg::XLEN-1:0]       op1_i,
    input  logic [ex_types_pkg::XLEN-1:0]       op2_i,
    output logic [ex_types_pkg::XLEN-1:0]       result_o
);

    localparam int W = ex_types_pkg::XLEN;

    logic [2:0]   funct3;
    logic         alt;
    logic         is_reg;
    logic         is_imm;
    logic [4:0]   shamt;
    logic [W-1:0] sum;
    logic [W-1:0] diff;
    logic [W-1:0] sra_res;
    logic         lt;
    logic         ltu;

    always_comb begin
        funct3 = inst_i.r_fmt.funct3;
        alt    = (inst_i.r_fmt.funct7 == riscv_isa_pkg::FUNCT7_ALT);
        is_reg = (inst_i.r_fmt.opcode == riscv_isa_pkg::OPC_OP);
        is_imm = (inst_i.r_fmt.opcode == riscv_isa_pkg::OPC_OP_IMM);
    end

    // immediate shifts take shamt straight from the instruction
    assign shamt = is_imm ? inst_i.i_fmt.imm12[4:0] : op2_i[4:0];

    always_comb begin
        sum     = op1_i + op2_i;
        diff    = op1_i - op2_i;
        sra_res = $signed(op1_i) >>> shamt;
        lt      = $signed(op1_i) < $signed(op2_i);
        ltu     = op1_i < op2_i;
    end

    always_comb begin
        result_o = sum; // LUI / AUIPC land here
        if (is_reg || is_imm) begin
            case (funct3)
                riscv_isa_pkg::F3_ADD_SUB: result_o = (is_reg && alt) ? diff : sum;
                riscv_isa_pkg::F3_SLL:     result_o = op1_i << shamt;
                riscv_isa_pkg::F3_SLT:     result_o = {{(W-1){1'b0}}, lt};
                riscv_isa_pkg::F3_SLTU:    result_o = {{(W-1){1'b0}}, ltu};
                riscv_isa_pkg::F3_XOR:     result_o = op1_i ^ op2_i;
                riscv_isa_pkg::F3_SR:      result_o = alt ? sra_res : (op1_i >> shamt);
                riscv_isa_pkg::F3_OR:      result_o = op1_i | op2_i;
                riscv_isa_pkg::F3_AND:     result_o = op1_i & op2_i;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/ex_mul.sv */
// ####################
// 32x32 multiplier, low or high word
// ####################
`timescale 1ns/1ps
`default_nettype none

module ex_mul (
    input  logic [2:0]                    funct3_i,
    input  logic [ex_types_pkg::XLEN-1:0] op1_i,
    input  logic [ex_types_pkg::XLEN-1:0] op2_i,
    output logic [ex_types_pkg::XLEN-1:0] result_o
);

    localparam int W = ex_types_pkg::XLEN;

    logic           signed1;
    logic           signed2;
    logic           neg1;
    logic           neg2;
    logic [W-1:0]   mag1;
    logic [W-1:0]   mag2;
    logic [2*W-1:0] prod;
    logic [2*W-1:0] prod_s;

    always_comb begin
        signed1 = (funct3_i == riscv_isa_pkg::F3_MULH) || (funct3_i == riscv_isa_pkg::F3_MULHSU);
        signed2 = (funct3_i == riscv_isa_pkg::F3_MULH);
        neg1    = signed1 & op1_i[W-1];
        neg2    = signed2 & op2_i[W-1];
        mag1    = neg1 ? (~op1_i + 1'b1) : op1_i;
        mag2    = neg2 ? (~op2_i + 1'b1) : op2_i;
        prod    = {{W{1'b0}}, mag1} * {{W{1'b0}}, mag2};
        prod_s  = (neg1 ^ neg2) ? (~prod + 1'b1) : prod; // restore sign
    end

    always_comb begin
        case (funct3_i)
            riscv_isa_pkg::F3_MUL: result_o = prod_s[W-1:0];
            default:               result_o = prod_s[2*W-1:W]; // mulh, mulhsu, mulhu
        endcase
    end

endmodule

`default_nettype wire

/* src/ex_branch.sv */
// ####################
// branch compare, target, link
// ####################
`timescale 1ns/1ps
`default_nettype none

module ex_branch (
    input  logic [2:0]                    funct3_i,
    input  logic                          is_jump_i,
    input  logic [ex_types_pkg::XLEN-1:0] rs1_data_i,
    input  logic [ex_types_pkg::XLEN-1:0] rs2_data_i,
    input  logic [ex_types_pkg::XLEN-1:0] op1_i,
    input  logic [ex_types_pkg::XLEN-1:0] op2_i,
    input  logic [ex_types_pkg::XLEN-1:0] pc_i,
    output logic                          taken_o,
    output logic [ex_types_pkg::XLEN-1:0] target_o,
    output logic [ex_types_pkg::XLEN-1:0] link_o
);

    logic eq;
    logic lt;
    logic ltu;
    logic cond;

    always_comb begin
        eq  = (rs1_data_i == rs2_data_i);
        lt  = $signed(rs1_data_i) < $signed(rs2_data_i);
        ltu = rs1_data_i < rs2_data_i;
        case (funct3_i)
            riscv_isa_pkg::F3_BEQ:  cond = eq;
            riscv_isa_pkg::F3_BNE:  cond = ~eq;
            riscv_isa_pkg::F3_BLT:  cond = lt;
            riscv_isa_pkg::F3_BGE:  cond = ~lt;
            riscv_isa_pkg::F3_BLTU: cond = ltu;
            riscv_isa_pkg::F3_BGEU: cond = ~ltu;
            default:                cond = 1'b0;
        endcase
    end

    assign taken_o  = is_jump_i | cond; // jal/jalr always taken
    assign target_o = taken_o ? (op1_i + op2_i) : '0;
    assign link_o   = pc_i + 32'd4;

endmodule

`default_nettype wire

/* src/ex_lsu.sv */
// ####################
// load/store unit, request register and load extraction
// ####################
`timescale 1ns/1ps
`default_nettype none

module ex_lsu (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                start_i,
    input  logic                                is_store_i,
    input  logic [2:0]                          funct3_i,
    input  logic [ex_types_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [ex_types_pkg::XLEN-1:0]       addr_base_i,
    input  logic [ex_types_pkg::XLEN-1:0]       addr_off_i,
    input  logic [ex_types_pkg::XLEN-1:0]       store_data_i,
    input  logic [ex_types_pkg::XLEN-1:0]       mem_rdata_i,
    input  logic                                mem_ready_i,
    output logic                                busy_o,
    output ex_types_pkg::ex_mem_req_t           mem_o,
    output logic                                load_done_o,
    output logic [ex_types_pkg::REG_ADDR_W-1:0] load_rd_o,
    output logic [ex_types_pkg::XLEN-1:0]       load_data_o
);

    localparam int W = ex_types_pkg::XLEN;

    logic                                req_q;
    logic                                we_q;
    logic [W-1:0]                        addr_q;
    logic [W-1:0]                        wdata_q;
    logic [2:0]                          funct3_q;
    logic [ex_types_pkg::REG_ADDR_W-1:0] rd_q;
    logic [7:0]                          lane_b;
    logic [15:0]                         lane_h;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            req_q <= 1'b0;
            we_q  <= 1'b0;
        end else if (start_i) begin
            req_q <= 1'b1;
            we_q  <= is_store_i;
        end else if (req_q && mem_ready_i) begin
            req_q <= 1'b0; // handshake done
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            addr_q   <= addr_base_i + addr_off_i;
            wdata_q  <= is_store_i ? store_data_i : '0;
            funct3_q <= funct3_i;
            rd_q     <= rd_i;
        end
    end

    always_comb begin
        mem_o.req   = req_q;
        mem_o.we    = we_q;
        mem_o.addr  = addr_q;
        mem_o.wdata = wdata_q;
    end

    always_comb begin
        case (addr_q[1:0])
            2'b00:   lane_b = mem_rdata_i[7:0];
            2'b01:   lane_b = mem_rdata_i[15:8];
            2'b10:   lane_b = mem_rdata_i[23:16];
            default: lane_b = mem_rdata_i[31:24];
        endcase
        lane_h = addr_q[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];

        case (funct3_q)
            riscv_isa_pkg::F3_LB:  load_data_o = {{24{lane_b[7]}}, lane_b};
            riscv_isa_pkg::F3_LH:  load_data_o = {{16{lane_h[15]}}, lane_h};
            riscv_isa_pkg::F3_LW:  load_data_o = mem_rdata_i;
            riscv_isa_pkg::F3_LBU: load_data_o = {24'h0, lane_b};
            riscv_isa_pkg::F3_LHU: load_data_o = {16'h0, lane_h};
            default:               load_data_o = mem_rdata_i;
        endcase
    end

    assign busy_o      = req_q;
    assign load_done_o = req_q & ~we_q & mem_ready_i;
    assign load_rd_o   = rd_q;

endmodule

`default_nettype wire

/* src/ex_stage.sv */
// ####################
// RV32IM execute stage top, unit decode and writeback register
// ####################
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  ex_types_pkg::ex_issue_t         issue_i,
    output logic                            ready_o,
    output ex_types_pkg::ex_mem_req_t       mem_o,
    input  logic [ex_types_pkg::XLEN-1:0]   mem_rdata_i,
    input  logic                            mem_ready_i,
    output ex_types_pkg::ex_wb_t            wb_o
);

    localparam int W = ex_types_pkg::XLEN;

    ex_types_pkg::ex_unit_e                unit;
    logic                                  is_jump;
    logic [6:0]                            opcode;
    logic [2:0]                            funct3;
    logic [6:0]                            funct7;
    logic                                  accept;
    logic                                  lsu_busy;
    logic                                  load_done;
    logic [ex_types_pkg::REG_ADDR_W-1:0]   load_rd;
    logic [W-1:0]                          load_data;
    logic [W-1:0]                          alu_res;
    logic [W-1:0]                          mul_res;
    logic                                  br_taken;
    logic [W-1:0]                          br_target;
    logic [W-1:0]                          br_link;
    ex_types_pkg::ex_wb_t                  wb_d;
    ex_types_pkg::ex_wb_t                  wb_q;

    // unit select
    always_comb begin
        opcode  = issue_i.inst.r_fmt.opcode;
        funct3  = issue_i.inst.r_fmt.funct3;
        funct7  = issue_i.inst.r_fmt.funct7;
        is_jump = (opcode == riscv_isa_pkg::OPC_JAL) || (opcode == riscv_isa_pkg::OPC_JALR);
        case (opcode)
            riscv_isa_pkg::OPC_OP: begin
                if (funct7 == riscv_isa_pkg::FUNCT7_MULDIV) begin
                    unit = funct3[2] ? ex_types_pkg::UNIT_NONE : ex_types_pkg::UNIT_MUL; // no div
                end else if (funct7 == riscv_isa_pkg::FUNCT7_BASE ||
                             funct7 == riscv_isa_pkg::FUNCT7_ALT) begin
                    unit = ex_types_pkg::UNIT_ALU;
                end else begin
                    unit = ex_types_pkg::UNIT_NONE;
                end
            end
            riscv_isa_pkg::OPC_OP_IMM,
            riscv_isa_pkg::OPC_LUI,
            riscv_isa_pkg::OPC_AUIPC:  unit = ex_types_pkg::UNIT_ALU;
            riscv_isa_pkg::OPC_BRANCH,
            riscv_isa_pkg::OPC_JAL,
            riscv_isa_pkg::OPC_JALR:   unit = ex_types_pkg::UNIT_BRANCH;
            riscv_isa_pkg::OPC_LOAD:   unit = ex_types_pkg::UNIT_LOAD;
            riscv_isa_pkg::OPC_STORE: begin
                // word stores only
                unit = (funct3 == riscv_isa_pkg::F3_SW) ? ex_types_pkg::UNIT_STORE
                                                        : ex_types_pkg::UNIT_NONE;
            end
            default:                   unit = ex_types_pkg::UNIT_NONE;
        endcase
    end

    assign ready_o = ~lsu_busy;
    assign accept  = issue_i.valid & ready_o;

    ex_alu u_alu (
        .inst_i   (issue_i.inst),
        .op1_i    (issue_i.op1),
        .op2_i    (issue_i.op2),
        .result_o (alu_res)
    );

    ex_mul u_mul (
        .funct3_i (funct3),
        .op1_i    (issue_i.op1),
        .op2_i    (issue_i.op2),
        .result_o (mul_res)
    );

    ex_branch u_branch (
        .funct3_i   (funct3),
        .is_jump_i  (is_jump),
        .rs1_data_i (issue_i.rs1_data),
        .rs2_data_i (issue_i.rs2_data),
        .op1_i      (issue_i.op1),
        .op2_i      (issue_i.op2),
        .pc_i       (issue_i.pc),
        .taken_o    (br_taken),
        .target_o   (br_target),
        .link_o     (br_link)
    );

    ex_lsu u_lsu (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .start_i      (accept && (unit == ex_types_pkg::UNIT_LOAD ||
                                  unit == ex_types_pkg::UNIT_STORE)),
        .is_store_i   (unit == ex_types_pkg::UNIT_STORE),
        .funct3_i     (funct3),
        .rd_i         (issue_i.inst.r_fmt.rd),
        .addr_base_i  (issue_i.op1),
        .addr_off_i   (issue_i.op2),
        .store_data_i (issue_i.store_data),
        .mem_rdata_i  (mem_rdata_i),
        .mem_ready_i  (mem_ready_i),
        .busy_o       (lsu_busy),
        .mem_o        (mem_o),
        .load_done_o  (load_done),
        .load_rd_o    (load_rd),
        .load_data_o  (load_data)
    );

    // result mux for single-cycle units
    always_comb begin
        wb_d           = '0;
        wb_d.valid     = 1'b1;
        wb_d.rd        = issue_i.inst.r_fmt.rd;
        case (unit)
            ex_types_pkg::UNIT_ALU: begin
                wb_d.we    = 1'b1;
                wb_d.wdata = alu_res;
            end
            ex_types_pkg::UNIT_MUL: begin
                wb_d.we    = 1'b1;
                wb_d.wdata = mul_res;
            end
            ex_types_pkg::UNIT_BRANCH: begin
                wb_d.we        = is_jump;
                wb_d.wdata     = is_jump ? br_link : '0;
                wb_d.jump      = br_taken;
                wb_d.jump_addr = br_target;
            end
            default: wb_d.we = 1'b0; // unsupported op retires as a no-op
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_q <= '0;
        end else if (load_done) begin
            wb_q.valid     <= 1'b1;
            wb_q.rd        <= load_rd;
            wb_q.we        <= 1'b1;
            wb_q.wdata     <= load_data;
            wb_q.jump      <= 1'b0;
            wb_q.jump_addr <= '0;
        end else if (accept && unit != ex_types_pkg::UNIT_LOAD &&
                     unit != ex_types_pkg::UNIT_STORE) begin
            wb_q <= wb_d;
        end else begin
            wb_q.valid <= 1'b0;
        end
    end

    assign wb_o = wb_q;

endmodule

`default_nettype wire

/* dv/ex_ref_model.svh */
// ####################
// expected results for ALU, multiply, branch and load
// ####################
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// op2 carries the shift amount for both register and immediate forms
function automatic logic [31:0] alu_expect(input riscv_isa_pkg::inst_u inst,
                                           input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    logic        alt;
    logic [4:0]  sh;
    alt = inst[30];
    sh  = b[4:0];
    case (inst.r_fmt.funct3)
        3'd0: begin
            if (inst.r_fmt.opcode == riscv_isa_pkg::OPC_OP && alt)
                res = a - b;
            else
                res = a + b;
        end
        3'd1: res = a << sh;
        3'd2: res = {31'b0, $signed(a) < $signed(b)};
        3'd3: res = {31'b0, a < b};
        3'd4: res = a ^ b;
        3'd5: begin
            if (alt)
                res = $signed(a) >>> sh;
            else
                res = a >> sh;
        end
        3'd6: res = a | b;
        default: res = a & b;
    endcase
    return res;
endfunction

function automatic logic [31:0] mul_expect(input logic [2:0] f3,
                                           input logic [31:0] a, input logic [31:0] b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] p;
    ea = (f3 == 3'd1 || f3 == 3'd2) ? {{32{a[31]}}, a} : {32'h0, a};
    eb = (f3 == 3'd1) ? {{32{b[31]}}, b} : {32'h0, b};
    p  = ea * eb; // low 64 bits hold the exact product
    return (f3 == 3'd0) ? p[31:0] : p[63:32];
endfunction

function automatic logic branch_expect(input logic [2:0] f3,
                                       input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        3'd7:    return a >= b;
        default: return 1'b0;
    endcase
endfunction

function automatic logic [31:0] load_expect(input logic [2:0] f3,
                                            input logic [31:0] word, input logic [1:0] off);
    logic [7:0]  b8;
    logic [15:0] h16;
    b8  = 8'(word >> (8 * off));
    h16 = 16'(word >> (16 * off[1]));
    case (f3)
        3'd0:    return {{24{b8[7]}}, b8};
        3'd1:    return {{16{h16[15]}}, h16};
        3'd4:    return {24'h0, b8};
        3'd5:    return {16'h0, h16};
        default: return word;
    endcase
endfunction

`endif

/* dv/tb_ex_stage.sv */
// ####################
// testbench for the execute stage, memory responder and watchdog
// ####################
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;

    `include "ex_ref_model.svh"

    localparam int N_ALU   = 60;
    localparam int N_MUL   = 40;
    localparam int N_BR    = 26;
    localparam int N_LOAD  = 20;
    localparam int N_STORE = 8;
    localparam int N_OPS   = N_ALU + N_MUL + N_BR + N_LOAD + 2 * N_STORE;
    localparam int WATCHDOG_NS = (N_OPS * 40 + 200) * 10;

    logic                      clk_i;
    logic                      rst_n_i;
    ex_types_pkg::ex_issue_t   issue_i;
    logic                      ready_o;
    ex_types_pkg::ex_mem_req_t mem_o;
    logic [31:0]               mem_rdata_i;
    logic                      mem_ready_i;
    ex_types_pkg::ex_wb_t      wb_o;

    logic [31:0] mem_array [16];
    int          wait_cnt;
    int          mismatch_cnt;
    int          other_cnt;

    ex_stage dut_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .issue_i     (issue_i),
        .ready_o     (ready_o),
        .mem_o       (mem_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ready_i (mem_ready_i),
        .wb_o        (wb_o)
    );

    always #5 clk_i = ~clk_i;

    // memory model, 0..3 wait cycles per request
    always @(negedge clk_i) begin
        mem_ready_i = 1'b0;
        if (rst_n_i && mem_o.req) begin
            if (wait_cnt < 0)
                wait_cnt = $urandom_range(0, 3);
            if (wait_cnt == 0) begin
                mem_ready_i = 1'b1;
                mem_rdata_i = mem_array[mem_o.addr[5:2]];
                if (mem_o.we)
                    mem_array[mem_o.addr[5:2]] = mem_o.wdata;
                wait_cnt = -1;
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

    task automatic mismatch(input string msg);
        mismatch_cnt++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    function automatic riscv_isa_pkg::inst_u make_inst(input logic [6:0] f7,
                                                       input logic [2:0] f3,
                                                       input logic [6:0] opc);
        riscv_isa_pkg::inst_u inst;
        inst.r_fmt = '{f7, 5'($urandom), 5'($urandom), f3, 5'($urandom), opc};
        return inst;
    endfunction

    function automatic ex_types_pkg::ex_wb_t make_wb(input logic [4:0] rd, input logic we,
                                                     input logic [31:0] wdata, input logic jump,
                                                     input logic [31:0] jaddr);
        return '{valid: 1'b1, rd: rd, we: we, wdata: wdata, jump: jump, jump_addr: jaddr};
    endfunction

    // accept at one rising edge, valid drops on the next falling edge
    task automatic send(input ex_types_pkg::ex_issue_t iss);
        @(negedge clk_i);
        issue_i = iss;
        issue_i.valid = 1'b1;
        @(posedge clk_i);
        assert (ready_o) else mismatch("ready_o low at issue");
        assert (!wb_o.valid) else mismatch("writeback valid for more than one cycle");
        @(negedge clk_i);
        issue_i.valid = 1'b0;
    endtask

    task automatic run_plain(input ex_types_pkg::ex_issue_t iss,
                             input ex_types_pkg::ex_wb_t exp);
        send(iss);
        @(posedge clk_i);
        assert (wb_o === exp)
            else mismatch($sformatf("wb %h, expected %h", wb_o, exp));
    endtask

    task automatic run_mem(input ex_types_pkg::ex_issue_t iss, input logic is_load,
                           input ex_types_pkg::ex_wb_t exp);
        ex_types_pkg::ex_mem_req_t first;
        int cycles;
        cycles = 0;
        send(iss);
        forever begin
            @(posedge clk_i);
            if (cycles == 0) begin
                first = mem_o;
                assert (mem_o.req && mem_o.we == !is_load && mem_o.addr == iss.op1 + iss.op2)
                    else mismatch($sformatf("request %h", mem_o));
                if (!is_load)
                    assert (mem_o.wdata == iss.store_data)
                        else mismatch($sformatf("store data %h", mem_o.wdata));
            end
            assert (mem_o === first) else mismatch("request changed while waiting");
            assert (!ready_o) else mismatch("ready_o high during a memory request");
            assert (!wb_o.valid) else mismatch("writeback during a memory request");
            if (mem_ready_i)
                break;
            cycles++;
            if (cycles > 10) begin
                other_cnt++;
                $display("memory request was never completed");
                return;
            end
        end
        @(posedge clk_i);
        assert (ready_o) else mismatch("ready_o low after completion");
        if (is_load)
            assert (wb_o === exp)
                else mismatch($sformatf("load wb %h, expected %h", wb_o, exp));
        else
            assert (!wb_o.valid) else mismatch("store produced a writeback");
    endtask

    initial begin
        ex_types_pkg::ex_issue_t iss;
        logic [31:0] corner [4];
        logic [2:0]  br_f3 [6];
        logic [2:0]  ld_f3 [5];
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [6:0]  opc;
        logic [31:0] word;
        logic        cond;
        corner = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h0000_0001};
        br_f3  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        ld_f3  = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        void'($urandom(32'hc361));
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        issue_i      = '0;
        mem_rdata_i  = '0;
        mem_ready_i  = 1'b0;
        wait_cnt     = -1;
        mismatch_cnt = 0;
        other_cnt    = 0;
        for (int i = 0; i < 16; i++)
            mem_array[i] = 32'h8070_f00f ^ (i * 32'h1111_1111);
        repeat (8) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(posedge clk_i);
        assert (!mem_o.req && !wb_o.valid && ready_o) else mismatch("state after reset");

        for (int i = 0; i < N_ALU; i++) begin
            f3  = 3'($urandom);
            opc = $urandom_range(0, 1) ? riscv_isa_pkg::OPC_OP : riscv_isa_pkg::OPC_OP_IMM;
            f7  = riscv_isa_pkg::FUNCT7_BASE;
            if (opc == riscv_isa_pkg::OPC_OP_IMM && f3 != 3'd1 && f3 != 3'd5)
                f7 = 7'($urandom); // upper immediate bits
            else if (f3 == 3'd5 || (f3 == 3'd0 && opc == riscv_isa_pkg::OPC_OP))
                f7 = $urandom_range(0, 1) ? riscv_isa_pkg::FUNCT7_ALT : f7;
            iss      = '0;
            iss.inst = make_inst(f7, f3, opc);
            iss.op1  = $urandom;
            iss.op2  = $urandom;
            if (opc == riscv_isa_pkg::OPC_OP_IMM)
                iss.op2 = {{20{iss.inst.i_fmt.imm12[11]}}, iss.inst.i_fmt.imm12};
            run_plain(iss, make_wb(iss.inst.r_fmt.rd, 1'b1,
                                   alu_expect(iss.inst, iss.op1, iss.op2), 1'b0, '0));
        end

        for (int i = 0; i < N_MUL; i++) begin
            f3       = 3'($urandom_range(0, 3));
            iss      = '0;
            iss.inst = make_inst(riscv_isa_pkg::FUNCT7_MULDIV, f3, riscv_isa_pkg::OPC_OP);
            iss.op1  = (i < 16) ? corner[i % 4] : $urandom;
            iss.op2  = (i < 16) ? corner[i / 4] : $urandom;
            run_plain(iss, make_wb(iss.inst.r_fmt.rd, 1'b1,
                                   mul_expect(f3, iss.op1, iss.op2), 1'b0, '0));
        end

        for (int i = 0; i < N_BR; i++) begin
            iss          = '0;
            iss.pc       = {30'($urandom), 2'b00};
            iss.rs1_data = (i % 3 == 2) ? corner[i % 4] : $urandom;
            // equal, just above, just below, then random
            case (i / 6)
                0:       iss.rs2_data = iss.rs1_data;
                1:       iss.rs2_data = iss.rs1_data + 32'd1;
                2:       iss.rs2_data = iss.rs1_data - 32'd1;
                default: iss.rs2_data = $urandom;
            endcase
            iss.op1      = iss.pc;
            iss.op2      = {{20{i[0]}}, 12'($urandom)};
            if (i < 24) begin
                f3       = br_f3[i % 6];
                iss.inst = make_inst(7'($urandom), f3, riscv_isa_pkg::OPC_BRANCH);
                cond     = branch_expect(f3, iss.rs1_data, iss.rs2_data);
                run_plain(iss, make_wb(iss.inst.r_fmt.rd, 1'b0, '0, cond,
                                       cond ? iss.op1 + iss.op2 : '0));
            end else begin
                opc      = (i == 24) ? riscv_isa_pkg::OPC_JAL : riscv_isa_pkg::OPC_JALR;
                iss.inst = make_inst(7'($urandom), 3'd0, opc);
                iss.op1  = (i == 24) ? iss.pc : $urandom; // jalr base is rs1
                run_plain(iss, make_wb(iss.inst.r_fmt.rd, 1'b1, iss.pc + 32'd4, 1'b1,
                                       iss.op1 + iss.op2));
            end
        end

        for (int i = 0; i < N_LOAD; i++) begin
            iss      = '0;
            f3       = ld_f3[i / 4];
            iss.inst = make_inst(7'($urandom), f3, riscv_isa_pkg::OPC_LOAD);
            iss.op1  = {26'h0, 4'($urandom), 2'b00};
            iss.op2  = i % 4;
            word     = mem_array[iss.op1[5:2]];
            run_mem(iss, 1'b1, make_wb(iss.inst.r_fmt.rd, 1'b1,
                                       load_expect(f3, word, 2'(i % 4)), 1'b0, '0));
        end

        for (int i = 0; i < N_STORE; i++) begin
            iss            = '0;
            iss.inst       = make_inst(7'($urandom), riscv_isa_pkg::F3_SW,
                                       riscv_isa_pkg::OPC_STORE);
            iss.op1        = {26'h0, 4'($urandom), 2'b00};
            iss.op2        = 32'h0;
            iss.store_data = $urandom;
            word           = iss.store_data;
            run_mem(iss, 1'b0, '0);
            iss.inst       = make_inst(7'($urandom), riscv_isa_pkg::F3_LW,
                                       riscv_isa_pkg::OPC_LOAD);
            run_mem(iss, 1'b1, make_wb(iss.inst.r_fmt.rd, 1'b1, word, 1'b0, '0));
        end

        repeat (2) @(posedge clk_i);
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt + other_cnt == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+dv
src/riscv_isa_pkg.sv
src/ex_types_pkg.sv
src/ex_alu.sv
src/ex_mul.sv
src/ex_branch.sv
src/ex_lsu.sv
src/ex_stage.sv
dv/tb_ex_stage.sv

/* run_sim.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -f compile.f --top-module tb_ex_stage -o sim_ex_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_ex_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "$out" | grep -qx "Finished with no errors" || exit 1
exit 0
